/* tb.f */
+incdir+verif
logic/bd_pkg.sv
logic/bundle_capture.sv
logic/branch_scan.sv
logic/branch_eval.sv
logic/issue_packer.sv
logic/branch_detect_top.sv
verif/tb_branch_detect.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_branch_detect -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?

if [ $sim_status -eq 0 ] && grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see sim.log"
exit 1

/* verif/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int nbits);
  logic [31:0] value;
  logic        fb;
  value = '0;
  for (int i = 0; i < nbits; i++) begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    value      = {value[30:0], fb};
  end
  return value;
endfunction

function automatic bd_pkg::opnd_t pick_operand(input bd_pkg::dep_tag_t tag,
                                               input bd_pkg::opnd_t grf,
                                               input bd_pkg::opnd_t byp);
  return (tag == 4'hf) ? grf : byp;
endfunction

function automatic logic cond_holds(input bd_pkg::inst_t inst, input bd_pkg::opnd_t l,
                                    input bd_pkg::opnd_t r);
  case (inst[1:0])
    2'd0:    return l == r;
    2'd1:    return l != r;
    2'd2:    return $signed(l) < $signed(r);
    default: return 1'b1;
  endcase
endfunction

function automatic bd_pkg::bundle_t keep_slots(input bd_pkg::bundle_t b, input int first,
                                               input int last);
  bd_pkg::bundle_t p;
  for (int s = 0; s < bd_pkg::MAX_SLOTS; s++) begin
    p[s] = (s >= first && s <= last) ? b[s] : '0;
  end
  return p;
endfunction

// walk the bundle in slot order, one packet per branch plus the tail
function automatic void expect_packets(input bd_pkg::bundle_t b, input bd_pkg::opnd_t grf_l,
                                       input bd_pkg::opnd_t grf_r, input bd_pkg::opnd_t byp_l,
                                       input bd_pkg::opnd_t byp_r);
  bd_pkg::opnd_t l;
  bd_pkg::opnd_t r;
  int            first;
  logic          done;
  exp_count = 0;
  first     = 0;
  done      = 1'b0;
  for (int s = 0; s < bd_pkg::MAX_SLOTS && !done; s++) begin
    if (b[s][7:5] == 3'b101) begin
      l = pick_operand(b[s][110:107], grf_l, byp_l);
      r = pick_operand(b[s][114:111], grf_r, byp_r);
      exp_pkt[exp_count]   = keep_slots(b, first, s);
      exp_redir[exp_count] = cond_holds(b[s], l, r);
      exp_pc[exp_count]    = b[s][106:75] + b[s][74:43];
      exp_last[exp_count]  = exp_redir[exp_count] || (s == bd_pkg::MAX_SLOTS - 1);
      done                 = exp_last[exp_count];
      exp_count++;
      first = s + 1;
    end
  end
  if (!done) begin
    exp_pkt[exp_count]   = keep_slots(b, first, bd_pkg::MAX_SLOTS - 1);
    exp_redir[exp_count] = 1'b0;
    exp_pc[exp_count]    = '0;
    exp_last[exp_count]  = 1'b1;
    exp_count++;
  end
endfunction

`endif

/* verif/tb_branch_detect.sv */
`timescale 1ns/1ps

module tb_branch_detect;

  localparam int NUM_ROWS       = 8;
  localparam int CLK_PERIOD     = 20;
  localparam int IDLE_CYCLES    = 4;
  localparam int CW             = bd_pkg::MAX_SLOTS * bd_pkg::INST_W;
  localparam int TIMEOUT_CYCLES = 24 + NUM_ROWS * (8 + 2 * bd_pkg::MAX_SLOTS);

  typedef struct packed {
    bd_pkg::slot_mask_t br_mask;
    logic [31:0]        conds;
    bd_pkg::dep_tag_t   dep_l;
    bd_pkg::dep_tag_t   dep_r;
    bd_pkg::opnd_t      grf_l;
    bd_pkg::opnd_t      grf_r;
    bd_pkg::opnd_t      byp_l;
    bd_pkg::opnd_t      byp_r;
  } row_t;

  logic            w_IssueFifoFire_1;
  logic            rstn;
  logic            i_bundle_valid;
  bd_pkg::bundle_t i_bundle;
  bd_pkg::opnd_t   i_grf_opnd_l;
  bd_pkg::opnd_t   i_grf_opnd_r;
  bd_pkg::opnd_t   i_byp_opnd_l;
  bd_pkg::opnd_t   i_byp_opnd_r;
  logic            o_ready;
  logic            o_issue_valid;
  logic            o_issue_last;
  bd_pkg::bundle_t o_packet;
  logic            o_redirect_valid;
  bd_pkg::opnd_t   o_redirect_pc;

  row_t            rows [NUM_ROWS];
  logic [31:0]     lfsr_state = 32'd85003;
  bd_pkg::bundle_t exp_pkt [bd_pkg::MAX_SLOTS];
  logic            exp_last [bd_pkg::MAX_SLOTS];
  logic            exp_redir [bd_pkg::MAX_SLOTS];
  bd_pkg::opnd_t   exp_pc [bd_pkg::MAX_SLOTS];
  int              exp_count;

  `include "tb_model.svh"

  branch_detect_top #(.NUM_SLOTS(16)) uut (
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .rstn              (rstn),
    .i_bundle_valid    (i_bundle_valid),
    .i_bundle          (i_bundle),
    .i_grf_opnd_l      (i_grf_opnd_l),
    .i_grf_opnd_r      (i_grf_opnd_r),
    .i_byp_opnd_l      (i_byp_opnd_l),
    .i_byp_opnd_r      (i_byp_opnd_r),
    .o_ready           (o_ready),
    .o_issue_valid     (o_issue_valid),
    .o_issue_last      (o_issue_last),
    .o_packet          (o_packet),
    .o_redirect_valid  (o_redirect_valid),
    .o_redirect_pc     (o_redirect_pc)
  );

  always #(CLK_PERIOD / 2) w_IssueFifoFire_1 = ~w_IssueFifoFire_1;

  task automatic check_value(input string name, input logic [CW-1:0] got,
                             input logic [CW-1:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  // random payload with opcodes forced so branches sit only where the row says
  function automatic bd_pkg::bundle_t build_bundle(input row_t row);
    bd_pkg::bundle_t b;
    logic [31:0]     hi;
    for (int s = 0; s < bd_pkg::MAX_SLOTS; s++) begin
      b[s][31:0]  = rand_bits(32);
      b[s][63:32] = rand_bits(32);
      b[s][95:64] = rand_bits(32);
      hi          = rand_bits(19);
      b[s][114:96] = hi[18:0];
      if (row.br_mask[s]) begin
        b[s][bd_pkg::OPC_LSB +: bd_pkg::OPC_W]   = bd_pkg::BJP_TYPE;
        b[s][bd_pkg::COND_LSB +: bd_pkg::COND_W] = row.conds[2*s +: 2];
        b[s][bd_pkg::DEPL_LSB +: bd_pkg::DEP_W]  = row.dep_l;
        b[s][bd_pkg::DEPR_LSB +: bd_pkg::DEP_W]  = row.dep_r;
      end else if (b[s][bd_pkg::OPC_LSB +: bd_pkg::OPC_W] == bd_pkg::BJP_TYPE) begin
        b[s][bd_pkg::OPC_LSB] = ~b[s][bd_pkg::OPC_LSB];
      end
    end
    return b;
  endfunction

  initial begin
    bd_pkg::bundle_t bundle;
    int              cyc;
    int              k;
    w_IssueFifoFire_1 = 1'b0;
    rstn              = 1'b0;
    i_bundle_valid    = 1'b0;
    i_bundle          = '0;
    i_grf_opnd_l      = '0;
    i_grf_opnd_r      = '0;
    i_byp_opnd_l      = '0;
    i_byp_opnd_r      = '0;
    // mask, conds, tag l, tag r, grf l, grf r, byp l, byp r
    rows[0] = '{16'h0000, 32'h00000000, 4'hf, 4'hf, 32'h5, 32'h6, 32'h7, 32'h8};
    rows[1] = '{16'h1108, 32'h01010040, 4'hf, 4'hf, 32'h1234, 32'h1234, 32'h1, 32'h2};
    rows[2] = '{16'h8020, 32'h00000000, 4'hf, 4'hf, 32'h1, 32'h2, 32'h3, 32'h3};
    rows[3] = '{16'h0890, 32'h0000c100, 4'hf, 4'hf, 32'h7, 32'h7, 32'h1, 32'h2};
    rows[4] = '{16'h0040, 32'h00000000, 4'hf, 4'hf, 32'h11, 32'h11, 32'h22, 32'h33};
    rows[5] = '{16'h0040, 32'h00000000, 4'h3, 4'h5, 32'h11, 32'h11, 32'h22, 32'h33};
    rows[6] = '{16'h0002, 32'h00000008, 4'hf, 4'h2, 32'hfffffffb, 32'h80000000, 32'h9, 32'h2};
    rows[7] = '{16'h4001, 32'h10000002, 4'hf, 4'hf, 32'h3, 32'hfffffffc, 32'h0, 32'h0};
    repeat (16) @(negedge w_IssueFifoFire_1);
    rstn = 1'b1;
    @(negedge w_IssueFifoFire_1);
    check_value("o_ready", CW'(o_ready), CW'(1'b1));
    check_value("o_issue_valid", CW'(o_issue_valid), CW'(1'b0));
    check_value("o_issue_last", CW'(o_issue_last), CW'(1'b0));
    check_value("o_redirect_valid", CW'(o_redirect_valid), CW'(1'b0));
    for (int r = 0; r < NUM_ROWS; r++) begin
      bundle = build_bundle(rows[r]);
      expect_packets(bundle, rows[r].grf_l, rows[r].grf_r, rows[r].byp_l, rows[r].byp_r);
      check_value("o_ready", CW'(o_ready), CW'(1'b1));
      i_bundle       = bundle;
      i_grf_opnd_l   = rows[r].grf_l;
      i_grf_opnd_r   = rows[r].grf_r;
      i_byp_opnd_l   = rows[r].byp_l;
      i_byp_opnd_r   = rows[r].byp_r;
      i_bundle_valid = 1'b1;
      k   = 0;
      cyc = 0;
      while (k < exp_count) begin
        @(negedge w_IssueFifoFire_1);
        cyc++;
        if (cyc == 1) begin
          // stray offer while busy must not be taken
          i_bundle = ~bundle;
        end else if (cyc == 2) begin
          i_bundle_valid = 1'b0;
        end
        if (o_issue_valid) begin
          check_value("o_packet", CW'(o_packet), CW'(exp_pkt[k]));
          check_value("o_issue_last", CW'(o_issue_last), CW'(exp_last[k]));
          check_value("o_redirect_valid", CW'(o_redirect_valid), CW'(exp_redir[k]));
          if (exp_redir[k]) begin
            check_value("o_redirect_pc", CW'(o_redirect_pc), CW'(exp_pc[k]));
          end
          // ready comes back with the last packet only
          check_value("o_ready", CW'(o_ready), CW'(exp_last[k]));
          k++;
        end else begin
          check_value("o_ready", CW'(o_ready), CW'(1'b0));
        end
      end
      // nothing more leaves once the bundle has ended
      repeat (IDLE_CYCLES) begin
        @(negedge w_IssueFifoFire_1);
        check_value("o_issue_valid", CW'(o_issue_valid), CW'(1'b0));
        check_value("o_ready", CW'(o_ready), CW'(1'b1));
      end
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: the DUT did not deliver the expected issue packets in time");
    $display("SOME TESTS FAILED");
    $fatal(1);
  end

endmodule

/* logic/branch_detect_top.sv */
`timescale 1ns/1ps

module branch_detect_top #(
  parameter int NUM_SLOTS = 16
) (
  input  logic            w_IssueFifoFire_1,
  input  logic            rstn,
  input  logic            i_bundle_valid,
  input  bd_pkg::bundle_t i_bundle,
  input  bd_pkg::opnd_t   i_grf_opnd_l,
  input  bd_pkg::opnd_t   i_grf_opnd_r,
  input  bd_pkg::opnd_t   i_byp_opnd_l,
  input  bd_pkg::opnd_t   i_byp_opnd_r,
  output logic            o_ready,
  output logic            o_issue_valid,
  output logic            o_issue_last,
  output bd_pkg::bundle_t o_packet,
  output logic            o_redirect_valid,
  output bd_pkg::opnd_t   o_redirect_pc
);

  logic               w_load;
  bd_pkg::bundle_t    w_bundle;
  bd_pkg::slot_mask_t w_mask;
  logic               w_seg_valid;
  bd_pkg::seg_t       w_seg;
  logic               w_res_valid;
  bd_pkg::resolved_t  w_res;

  bundle_capture #(.NUM_SLOTS(NUM_SLOTS)) u_capture (
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .rstn              (rstn),
    .i_bundle_valid    (i_bundle_valid),
    .i_ready           (o_ready),
    .i_bundle          (i_bundle),
    .o_load            (w_load),
    .o_bundle          (w_bundle),
    .o_mask            (w_mask)
  );

  branch_scan #(.NUM_SLOTS(NUM_SLOTS)) u_scan (
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .rstn              (rstn),
    .i_load            (w_load),
    .i_bundle          (w_bundle),
    .i_mask            (w_mask),
    .i_res_valid       (w_res_valid),
    .i_res             (w_res),
    .o_seg_valid       (w_seg_valid),
    .o_seg             (w_seg),
    .o_ready           (o_ready)
  );

  branch_eval u_eval (
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .rstn              (rstn),
    .i_seg_valid       (w_seg_valid),
    .i_seg             (w_seg),
    .i_grf_opnd_l      (i_grf_opnd_l),
    .i_grf_opnd_r      (i_grf_opnd_r),
    .i_byp_opnd_l      (i_byp_opnd_l),
    .i_byp_opnd_r      (i_byp_opnd_r),
    .o_res_valid       (w_res_valid),
    .o_res             (w_res)
  );

  issue_packer #(.NUM_SLOTS(NUM_SLOTS)) u_packer (
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .rstn              (rstn),
    .i_bundle          (w_bundle),
    .i_res_valid       (w_res_valid),
    .i_res             (w_res),
    .o_issue_valid     (o_issue_valid),
    .o_issue_last      (o_issue_last),
    .o_packet          (o_packet),
    .o_redirect_valid  (o_redirect_valid),
    .o_redirect_pc     (o_redirect_pc)
  );

endmodule

/* logic/issue_packer.sv */
`timescale 1ns/1ps

module issue_packer #(
  parameter int NUM_SLOTS = 16
) (
  input  logic              w_IssueFifoFire_1,
  input  logic              rstn,
  input  bd_pkg::bundle_t   i_bundle,
  input  logic              i_res_valid,
  input  bd_pkg::resolved_t i_res,
  output logic              o_issue_valid,
  output logic              o_issue_last,
  output bd_pkg::bundle_t   o_packet,
  output logic              o_redirect_valid,
  output bd_pkg::opnd_t     o_redirect_pc
);

  bd_pkg::bundle_t w_packet;
  logic            w_last;

  // keep first..last, everything else becomes a nop
  always_comb begin
    for (int i = 0; i < bd_pkg::MAX_SLOTS; i++) begin
      if ((i < NUM_SLOTS) && (i >= int'(i_res.seg.first)) && (i <= int'(i_res.seg.last))) begin
        w_packet[i] = i_bundle[i];
      end else begin
        w_packet[i] = '0;
      end
    end
  end

  assign w_last = i_res.taken | i_res.seg.final_seg;

  always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_issue_valid    <= 1'b0;
      o_issue_last     <= 1'b0;
      o_redirect_valid <= 1'b0;
    end else begin
      o_issue_valid    <= i_res_valid;
      o_issue_last     <= i_res_valid & w_last;
      o_redirect_valid <= i_res_valid & i_res.taken;
    end
  end

  always_ff @(posedge w_IssueFifoFire_1) begin
    if (i_res_valid) begin
      o_packet      <= w_packet;
      o_redirect_pc <= i_res.target;
    end
  end

endmodule

/* logic/branch_eval.sv */
`timescale 1ns/1ps

module branch_eval (
  input  logic              w_IssueFifoFire_1,
  input  logic              rstn,
  input  logic              i_seg_valid,
  input  bd_pkg::seg_t      i_seg,
  input  bd_pkg::opnd_t     i_grf_opnd_l,
  input  bd_pkg::opnd_t     i_grf_opnd_r,
  input  bd_pkg::opnd_t     i_byp_opnd_l,
  input  bd_pkg::opnd_t     i_byp_opnd_r,
  output logic              o_res_valid,
  output bd_pkg::resolved_t o_res
);

  bd_pkg::inst_t     w_inst;
  bd_pkg::dep_tag_t  w_dep_l;
  bd_pkg::dep_tag_t  w_dep_r;
  bd_pkg::opnd_t     w_opnd_l;
  bd_pkg::opnd_t     w_opnd_r;
  bd_pkg::opnd_t     w_pc;
  bd_pkg::opnd_t     w_imm;
  bd_pkg::br_cond_e  w_cond;
  logic              w_cond_true;
  bd_pkg::resolved_t w_res;

  assign w_inst  = i_seg.br_inst;
  assign w_dep_l = w_inst[bd_pkg::DEPL_LSB +: bd_pkg::DEP_W];
  assign w_dep_r = w_inst[bd_pkg::DEPR_LSB +: bd_pkg::DEP_W];
  assign w_pc    = w_inst[bd_pkg::PC_LSB +: bd_pkg::OPND_W];
  assign w_imm   = w_inst[bd_pkg::IMM_LSB +: bd_pkg::OPND_W];
  assign w_cond  = bd_pkg::br_cond_e'(w_inst[bd_pkg::COND_LSB +: bd_pkg::COND_W]);

  // operand source by tag
  assign w_opnd_l = (w_dep_l == bd_pkg::NO_DEP) ? i_grf_opnd_l : i_byp_opnd_l;
  assign w_opnd_r = (w_dep_r == bd_pkg::NO_DEP) ? i_grf_opnd_r : i_byp_opnd_r;

  always_comb begin
    w_cond_true = 1'b0;
    case (w_cond)
      bd_pkg::COND_EQ:     w_cond_true = (w_opnd_l == w_opnd_r);
      bd_pkg::COND_NE:     w_cond_true = (w_opnd_l != w_opnd_r);
      bd_pkg::COND_LT:     w_cond_true = ($signed(w_opnd_l) < $signed(w_opnd_r));
      bd_pkg::COND_ALWAYS: w_cond_true = 1'b1;
    endcase
  end

  // tail segments never redirect
  assign w_res.seg    = i_seg;
  assign w_res.taken  = i_seg.has_branch & w_cond_true;
  assign w_res.target = w_pc + w_imm;

  always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_res_valid <= 1'b0;
    end else begin
      o_res_valid <= i_seg_valid;
    end
  end

  always_ff @(posedge w_IssueFifoFire_1) begin
    if (i_seg_valid) begin
      o_res <= w_res;
    end
  end

endmodule

/* logic/branch_scan.sv */
`timescale 1ns/1ps

module branch_scan #(
  parameter int NUM_SLOTS = 16
) (
  input  logic               w_IssueFifoFire_1,
  input  logic               rstn,
  input  logic               i_load,
  input  bd_pkg::bundle_t    i_bundle,
  input  bd_pkg::slot_mask_t i_mask,
  input  logic               i_res_valid,
  input  bd_pkg::resolved_t  i_res,
  output logic               o_seg_valid,
  output bd_pkg::seg_t       o_seg,
  output logic               o_ready
);

  localparam bd_pkg::slot_idx_t LAST_SLOT = bd_pkg::slot_idx_t'(NUM_SLOTS - 1);

  bd_pkg::scan_state_e state;
  bd_pkg::slot_mask_t  r_rem;
  bd_pkg::slot_idx_t   r_first;

  bd_pkg::slot_mask_t  w_rem;
  bd_pkg::slot_mask_t  w_rem_next;
  bd_pkg::slot_idx_t   w_first;
  bd_pkg::slot_idx_t   w_idx;
  bd_pkg::seg_t        w_seg;
  logic                w_done;
  logic                w_step;

  function automatic bd_pkg::slot_idx_t lowest_set(input bd_pkg::slot_mask_t m);
    bd_pkg::slot_idx_t idx;
    idx = '0;
    for (int i = bd_pkg::MAX_SLOTS - 1; i >= 0; i--) begin
      if (m[i]) begin
        idx = bd_pkg::slot_idx_t'(i);
      end
    end
    return idx;
  endfunction

  // a load restarts from slot 0 with the fresh mask
  assign w_rem   = i_load ? i_mask : r_rem;
  assign w_first = i_load ? '0 : r_first;
  assign w_idx   = lowest_set(w_rem);

  always_comb begin
    w_rem_next        = w_rem;
    w_rem_next[w_idx] = 1'b0;
  end

  always_comb begin
    w_seg.first = w_first;
    if (|w_rem) begin
      w_seg.last       = w_idx;
      w_seg.has_branch = 1'b1;
      w_seg.final_seg  = (w_rem_next == '0) && (w_idx == LAST_SLOT);
      w_seg.br_inst    = i_bundle[w_idx];
    end else begin
      // tail after the last branch
      w_seg.last       = LAST_SLOT;
      w_seg.has_branch = 1'b0;
      w_seg.final_seg  = 1'b1;
      w_seg.br_inst    = '0;
    end
  end

  assign w_done = i_res.taken | i_res.seg.final_seg;
  assign w_step = ((state == bd_pkg::SCAN_IDLE) && i_load) ||
                  ((state == bd_pkg::SCAN_WAIT) && i_res_valid && !w_done);

  always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      state   <= bd_pkg::SCAN_IDLE;
      r_rem   <= '0;
      r_first <= '0;
    end else begin
      case (state)
        bd_pkg::SCAN_IDLE: if (i_load) state <= bd_pkg::SCAN_EMIT;
        bd_pkg::SCAN_EMIT: state <= bd_pkg::SCAN_WAIT;
        bd_pkg::SCAN_WAIT: begin
          if (i_res_valid) begin
            state <= w_done ? bd_pkg::SCAN_IDLE : bd_pkg::SCAN_EMIT;
          end
        end
        default: state <= bd_pkg::SCAN_IDLE;
      endcase
      if (w_step) begin
        r_rem   <= w_rem_next;
        r_first <= w_idx + bd_pkg::slot_idx_t'(1);
      end
    end
  end

  always_ff @(posedge w_IssueFifoFire_1) begin
    if (w_step) begin
      o_seg <= w_seg;
    end
  end

  assign o_seg_valid = (state == bd_pkg::SCAN_EMIT);
  // busy already in the cycle the load is out
  assign o_ready     = (state == bd_pkg::SCAN_IDLE) && !i_load;

endmodule

/* logic/bundle_capture.sv */
`timescale 1ns/1ps

module bundle_capture #(
  parameter int NUM_SLOTS = 16
) (
  input  logic               w_IssueFifoFire_1,
  input  logic               rstn,
  input  logic               i_bundle_valid,
  input  logic               i_ready,
  input  bd_pkg::bundle_t    i_bundle,
  output logic               o_load,
  output bd_pkg::bundle_t    o_bundle,
  output bd_pkg::slot_mask_t o_mask
);

  logic               w_accept;
  bd_pkg::slot_mask_t w_mask;

  assign w_accept = i_bundle_valid & i_ready;

  // branch marks, unused slots never marked
  always_comb begin
    for (int i = 0; i < bd_pkg::MAX_SLOTS; i++) begin
      w_mask[i] = (i < NUM_SLOTS) &&
                  (i_bundle[i][bd_pkg::OPC_LSB +: bd_pkg::OPC_W] == bd_pkg::BJP_TYPE);
    end
  end

  always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_load <= 1'b0;
      o_mask <= '0;
    end else begin
      o_load <= w_accept;
      if (w_accept) begin
        o_mask <= w_mask;
      end
    end
  end

  always_ff @(posedge w_IssueFifoFire_1) begin
    if (w_accept) begin
      o_bundle <= i_bundle;
    end
  end

endmodule

/* logic/bd_pkg.sv */
package bd_pkg;

  localparam int MAX_SLOTS = 16;
  localparam int INST_W    = 115;
  localparam int OPND_W    = 32;
  localparam int SLOT_W    = $clog2(MAX_SLOTS);
  localparam int DEP_W     = 4;
  localparam int OPC_W     = 3;
  localparam int COND_W    = 2;

  // instruction field positions
  localparam int COND_LSB = 0;
  localparam int OPC_LSB  = 5;
  localparam int IMM_LSB  = 43;
  localparam int PC_LSB   = 75;
  localparam int DEPL_LSB = 107;
  localparam int DEPR_LSB = 111;

  typedef logic [INST_W-1:0]    inst_t;
  typedef logic [OPND_W-1:0]    opnd_t;
  typedef logic [SLOT_W-1:0]    slot_idx_t;
  typedef logic [MAX_SLOTS-1:0] slot_mask_t;
  typedef logic [DEP_W-1:0]     dep_tag_t;

  localparam logic [OPC_W-1:0] BJP_TYPE = 3'b101;
  // all ones means no producer in flight
  localparam dep_tag_t NO_DEP = '1;

  typedef enum logic [COND_W-1:0] {
    COND_EQ,
    COND_NE,
    COND_LT,
    COND_ALWAYS
  } br_cond_e;

  typedef enum logic [1:0] {
    SCAN_IDLE,
    SCAN_EMIT,
    SCAN_WAIT
  } scan_state_e;

  typedef inst_t [MAX_SLOTS-1:0] bundle_t;

  typedef struct packed {
    slot_idx_t first;
    slot_idx_t last;
    logic      has_branch;
    logic      final_seg;
    inst_t     br_inst;
  } seg_t;

  typedef struct packed {
    seg_t  seg;
    logic  taken;
    opnd_t target;
  } resolved_t;

endpackage
